// ==== tb.f ====
+incdir+include
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/decode_stage.sv
hdl/register_file.sv
hdl/execute_stage.sv
hdl/rv_core_top.sv
tb/tb_rv_core.sv

// ==== Bender.yml ====
package:
  name: rv_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - hdl/rv_isa_pkg.sv
      - hdl/core_pkg.sv
      - hdl/decode_stage.sv
      - hdl/register_file.sv
      - hdl/execute_stage.sv
      - hdl/rv_core_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - tb/tb_rv_core.sv

// ==== tb/tb_rv_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module tb_rv_core;
  import rv_isa_pkg::*;
  import core_pkg::*;

  localparam int DRIVE_DLY  = 2;
  localparam int WAIT_LIMIT = 50;

  logic    clk;
  logic    rst_n;
  inst_t   inst;
  logic    inst_valid;
  logic    inst_ready;
  retire_t retire;
  word_t   pc;
  logic    halted;

  // reference model with one queue entry per accepted instruction
  word_t       model_regs [`REG_COUNT];
  word_t       model_pc;
  logic        model_halted;
  retire_t     exp_q [$];
  retire_t     exp_head;
  logic [31:0] rng_state;
  int          accepted;
  int          retired;
  int          parked;

  rv_core_top i_rv_core_top (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .retire     (retire),
    .pc         (pc),
    .halted     (halted)
  );

  // 40 ns period
  always #20 clk = ~clk;

  task automatic stop_with_failure(input string why);
    $display("%s", why);
    $display("Test FAILED");
    $fatal(1, "simulation stopped at first error");
  endtask

  task automatic report_value(input string name, input word_t exp, input word_t act);
    stop_with_failure($sformatf("ERROR at %0t ns: %s expected 0x%h actual 0x%h",
                                $time, name, exp, act));
  endtask

  // numerical recipes lcg
  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // upper lcg bits have the longer period
  function automatic int pick(input int n);
    return int'((next_random() >> 16) % n);
  endfunction

  function automatic inst_t itype_word(input opcode_e op, input reg_idx_t rd,
                                       input reg_idx_t rs1, input logic [11:0] imm);
    return {imm, rs1, 3'b000, rd, op};
  endfunction

  function automatic inst_t utype_word(input opcode_e op, input reg_idx_t rd,
                                       input logic [19:0] imm);
    return {imm, rd, op};
  endfunction

  // imm[20|10:1|11|19:12] scramble
  function automatic inst_t jal_word(input reg_idx_t rd, input logic [20:0] imm);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, JAL};
  endfunction

  // kind 0 to 4 picks addi lui auipc jal jalr and anything above a no-op
  function automatic inst_t rand_inst(input int kind, input reg_idx_t rs1);
    logic [31:0] r;
    reg_idx_t    rd;
    r  = next_random();
    rd = reg_idx_t'(pick(32));
    case (kind)
      0: return itype_word(OP_IMM, rd, rs1, r[31:20]);
      1: return utype_word(LUI, rd, r[31:12]);
      2: return utype_word(AUIPC, rd, r[31:12]);
      3: return jal_word(rd, {r[31:12], 1'b0});
      4: return itype_word(JALR, rd, rs1, r[31:20]);
      // r-type add that this core retires as a no-op
      default: return {r[31:7], 7'b011_0011};
    endcase
  endfunction

  // expected retire record straight from the ISA rules
  task automatic model_step(input inst_t word);
    retire_t rec;
    word_t   src;
    word_t   imm_i;
    word_t   imm_u;
    word_t   imm_j;
    imm_i = word_t'($signed(word[31:20]));
    imm_u = word & 32'hffff_f000;
    imm_j = word_t'($signed({word[31], word[19:12], word[20], word[30:21], 1'b0}));
    // rs1 read before rd is updated
    src   = model_regs[word[19:15]];
    rec           = '0;
    rec.valid     = 1'b1;
    rec.pc        = model_pc;
    rec.rd        = word[11:7];
    rec.reg_write = 1'b1;
    rec.next_pc   = model_pc + 32'd4;
    case (word[6:0])
      OP_IMM: rec.wdata = src + imm_i;
      LUI:    rec.wdata = imm_u;
      AUIPC:  rec.wdata = model_pc + imm_u;
      JAL: begin
        rec.wdata   = model_pc + 32'd4;
        rec.next_pc = model_pc + imm_j;
      end
      JALR: begin
        rec.wdata   = model_pc + 32'd4;
        rec.next_pc = (src + imm_i) & ~32'd1;
      end
      SYSTEM: begin
        // ebreak parks the pc on itself
        rec.reg_write = 1'b0;
        rec.next_pc   = model_pc;
        model_halted  = 1'b1;
      end
      default: rec.reg_write = 1'b0;
    endcase
    if (rec.reg_write && rec.rd != 0) begin
      model_regs[rec.rd] = rec.wdata;
    end
    model_pc = rec.next_pc;
    exp_q.push_back(rec);
  endtask

  // bookkeeping between edges where all signals are settled
  always @(negedge clk) begin
    if (rst_n && retire.valid) begin
      if (exp_q.size() == 0) begin
        stop_with_failure("retire record seen with no accepted instruction pending");
      end else begin
        exp_head = exp_q.pop_front();
        retired++;
      end
    end
    // transfer happens at the coming rising edge
    if (rst_n && inst_valid && inst_ready) begin
      if (model_halted) begin
        // stuck in the decode register behind ebreak
        parked++;
      end else begin
        model_step(inst);
        accepted++;
      end
    end
  end

  a_retire_pc: assert property (@(posedge clk) disable iff (!rst_n)
    retire.valid |-> retire.pc == exp_head.pc)
    else report_value("retire.pc", $sampled(exp_head.pc), $sampled(retire.pc));

  a_retire_we: assert property (@(posedge clk) disable iff (!rst_n)
    retire.valid |-> retire.reg_write == exp_head.reg_write)
    else report_value("retire.reg_write", $sampled(exp_head.reg_write),
                      $sampled(retire.reg_write));

  a_retire_next: assert property (@(posedge clk) disable iff (!rst_n)
    retire.valid |-> retire.next_pc == exp_head.next_pc)
    else report_value("retire.next_pc", $sampled(exp_head.next_pc),
                      $sampled(retire.next_pc));

  // rd and wdata only mean something on a write
  a_retire_rd: assert property (@(posedge clk) disable iff (!rst_n)
    retire.valid && exp_head.reg_write |-> retire.rd == exp_head.rd)
    else report_value("retire.rd", $sampled(exp_head.rd), $sampled(retire.rd));

  a_retire_wdata: assert property (@(posedge clk) disable iff (!rst_n)
    retire.valid && exp_head.reg_write |-> retire.wdata == exp_head.wdata)
    else report_value("retire.wdata", $sampled(exp_head.wdata), $sampled(retire.wdata));

  // present the word until the core takes it
  // valid stays high on return
  task automatic send_inst(input inst_t word);
    int waited;
    inst       = word;
    inst_valid = 1'b1;
    waited     = 0;
    @(negedge clk);
    while (!inst_ready && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!inst_ready) begin
      stop_with_failure("timeout waiting for inst_ready to accept an instruction");
    end
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // bubble in the stream with junk on inst
  task automatic idle(input int cycles);
    inst_valid = 1'b0;
    inst       = next_random();
    repeat (cycles) begin
      @(posedge clk);
      #DRIVE_DLY;
    end
  endtask

  initial begin
    reg_idx_t last_rd;
    inst_t    word;
    int       waited;
    clk          = 1'b0;
    rst_n        = 1'b0;
    inst         = '0;
    inst_valid   = 1'b0;
    rng_state    = 32'd72067;
    accepted     = 0;
    retired      = 0;
    parked       = 0;
    model_pc     = `RESET_PC;
    model_halted = 1'b0;
    exp_head     = '0;
    for (int i = 0; i < `REG_COUNT; i++) begin
      model_regs[i] = '0;
    end
    repeat (3) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;

    // state right out of reset
    @(negedge clk);
    assert (pc == `RESET_PC) else report_value("pc", `RESET_PC, pc);
    assert (!retire.valid && !halted && inst_ready)
      else stop_with_failure("retire.valid, halted or inst_ready wrong after reset");
    @(posedge clk);
    #DRIVE_DLY;

    // addi chain mostly reading the previous rd
    send_inst(itype_word(OP_IMM, 5'd1, 5'd0, 12'h123));
    last_rd = 5'd1;
    for (int i = 0; i < 30; i++) begin
      word    = rand_inst(0, (pick(4) == 0) ? reg_idx_t'(pick(32)) : last_rd);
      last_rd = word[11:7];
      send_inst(word);
    end
    // dropped write to x0 then a read of x0
    send_inst(itype_word(OP_IMM, 5'd0, 5'd1, 12'h7ff));
    send_inst(itype_word(OP_IMM, 5'd2, 5'd0, 12'h805));

    // lui and auipc
    for (int i = 0; i < 12; i++) begin
      send_inst(rand_inst(1 + pick(2), 5'd0));
    end

    // each jump followed by an addi that retires at the target
    for (int i = 0; i < 12; i++) begin
      send_inst(rand_inst(3 + pick(2), reg_idx_t'(pick(32))));
      send_inst(rand_inst(0, reg_idx_t'(pick(32))));
    end

    // full mix with random bubbles
    for (int i = 0; i < 150; i++) begin
      if (pick(3) == 0) begin
        idle(1 + pick(3));
      end
      send_inst(rand_inst(pick(6), reg_idx_t'(pick(32))));
    end
    idle(1);
    waited = 0;
    while (exp_q.size() != 0 && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (exp_q.size() != 0) begin
      stop_with_failure("timeout waiting for accepted instructions to retire");
    end

    // ebreak halts the core for good
    send_inst(32'h0010_0073);
    // follower fills the decode register and never leaves it
    inst       = rand_inst(0, 5'd3);
    inst_valid = 1'b1;
    waited     = 0;
    while (!halted && waited < WAIT_LIMIT) begin
      @(negedge clk);
      waited++;
    end
    if (!halted) begin
      stop_with_failure("timeout waiting for halted after ebreak");
    end
    @(posedge clk);
    #DRIVE_DLY;
    for (int i = 0; i < 20; i++) begin
      @(negedge clk);
      assert (!inst_ready) else stop_with_failure("inst_ready high while halted");
      assert (!retire.valid) else stop_with_failure("retire record appeared while halted");
      assert (pc == model_pc) else report_value("pc", model_pc, pc);
    end
    inst_valid = 1'b0;

    if (exp_q.size() == 0 && retired == accepted && parked == 1) begin
      $display("Test OK");
      $finish;
    end else begin
      stop_with_failure("accepted instructions do not match retired ones plus one parked");
    end
  end

endmodule

`default_nettype wire

// ==== hdl/rv_core_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module rv_core_top (
  input  logic              clk,
  input  logic              rst_n,
  input  rv_isa_pkg::inst_t inst,
  input  logic              inst_valid,
  output logic              inst_ready,
  output core_pkg::retire_t retire,
  output rv_isa_pkg::word_t pc,
  output logic              halted
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  // decode to execute
  decoded_t dec;
  logic     dec_valid;
  logic     exec_ready;

  // execute to register file
  reg_idx_t rs1_addr;
  word_t    rs1_data;
  logic     wen;
  reg_idx_t waddr;
  word_t    wdata;

  decode_stage i_decode_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst       (inst),
    .inst_valid (inst_valid),
    .inst_ready (inst_ready),
    .dec        (dec),
    .dec_valid  (dec_valid),
    .exec_ready (exec_ready)
  );

  execute_stage i_execute_stage (
    .clk        (clk),
    .rst_n      (rst_n),
    .dec        (dec),
    .dec_valid  (dec_valid),
    .exec_ready (exec_ready),
    .rs1_addr   (rs1_addr),
    .rs1_data   (rs1_data),
    .wen        (wen),
    .waddr      (waddr),
    .wdata      (wdata),
    .pc         (pc),
    .retire     (retire),
    .halted     (halted)
  );

  register_file i_register_file (
    .clk      (clk),
    .rst_n    (rst_n),
    .rs1_addr (rs1_addr),
    .rs1_data (rs1_data),
    .wen      (wen),
    .waddr    (waddr),
    .wdata    (wdata)
  );

endmodule

`default_nettype wire

// ==== hdl/execute_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module execute_stage (
  input  logic                 clk,
  input  logic                 rst_n,
  input  core_pkg::decoded_t   dec,
  input  logic                 dec_valid,
  output logic                 exec_ready,
  output rv_isa_pkg::reg_idx_t rs1_addr,
  input  rv_isa_pkg::word_t    rs1_data,
  output logic                 wen,
  output rv_isa_pkg::reg_idx_t waddr,
  output rv_isa_pkg::word_t    wdata,
  output rv_isa_pkg::word_t    pc,
  output core_pkg::retire_t    retire,
  output logic                 halted
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  logic  take;
  word_t op_a;
  word_t sum;
  word_t link;
  word_t next_pc;
  word_t wb_data;

  // stall forever once ebreak retired
  assign exec_ready = !halted;
  assign take       = dec_valid && exec_ready;

  // rs1 read straight from the decode register
  assign rs1_addr = dec.rs1;

  always_comb begin
    case (dec.src_a)
      SRC_RS1: begin
        op_a = rs1_data;
      end
      SRC_PC: begin
        op_a = pc;
      end
      default: begin
        op_a = '0;
      end
    endcase
  end

  // single adder serves all kept instructions
  assign sum  = op_a + dec.imm;
  assign link = pc + `PC_STEP;

  always_comb begin
    if (dec.is_halt) begin
      // ebreak parks the pc on itself
      next_pc = pc;
    end else if (dec.is_jump) begin
      // jalr needs bit 0 cleared
      // jal target already even, so clearing it there is harmless
      next_pc = {sum[`XLEN-1:1], 1'b0};
    end else begin
      next_pc = link;
    end
  end

  assign wb_data = (dec.wb_sel == WB_LINK) ? link : sum;

  // write lands on the same edge as the retire record
  assign wen   = take && dec.reg_write;
  assign waddr = dec.rd;
  assign wdata = wb_data;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc     <= `RESET_PC;
      halted <= 1'b0;
    end else if (take) begin
      pc <= next_pc;
      if (dec.is_halt) begin
        halted <= 1'b1;
      end
    end
  end

  // one-cycle retire pulse, fields hold between pulses
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      retire <= '0;
    end else begin
      retire.valid <= take;
      if (take) begin
        retire.pc        <= pc;
        retire.rd        <= dec.rd;
        retire.reg_write <= dec.reg_write;
        retire.wdata     <= wb_data;
        retire.next_pc   <= next_pc;
      end
    end
  end

  // ebreak's own record is the last one
  a_no_retire_halted: assert property (
    @(posedge clk) disable iff (!rst_n)
    halted |=> !retire.valid
  );

  a_halt_sticky: assert property (
    @(posedge clk) disable iff (!rst_n)
    halted |=> halted
  );

endmodule

`default_nettype wire

// ==== hdl/register_file.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module register_file (
  input  logic                 clk,
  input  logic                 rst_n,
  input  rv_isa_pkg::reg_idx_t rs1_addr,
  output rv_isa_pkg::word_t    rs1_data,
  input  logic                 wen,
  input  rv_isa_pkg::reg_idx_t waddr,
  input  rv_isa_pkg::word_t    wdata
);
  import rv_isa_pkg::*;

  word_t regs [`REG_COUNT];

  // x0 is never written
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && (waddr != '0)) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational read
  // written value is visible the cycle after the write edge
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];

  a_x0_zero: assert property (
    @(posedge clk) disable iff (!rst_n)
    regs[0] == '0
  );

endmodule

`default_nettype wire

// ==== hdl/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "core_defs.svh"

module decode_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  rv_isa_pkg::inst_t  inst,
  input  logic               inst_valid,
  output logic               inst_ready,
  output core_pkg::decoded_t dec,
  output logic               dec_valid,
  input  logic               exec_ready
);
  import rv_isa_pkg::*;
  import core_pkg::*;

  opcode_e  opcode;
  word_t    imm_i;
  word_t    imm_u;
  word_t    imm_j;
  decoded_t dec_next;
  logic     accept;

  assign opcode = opcode_e'(inst[6:0]);

  // sign-extended 12-bit immediate
  assign imm_i = {{(`XLEN-12){inst[31]}}, inst[31:20]};
  // upper 20 bits, low 12 zero
  assign imm_u = {inst[31:12], 12'h000};
  // scrambled jump offset, bit 0 always zero
  assign imm_j = {{(`XLEN-20){inst[31]}}, inst[19:12], inst[20], inst[30:21], 1'b0};

  always_comb begin
    // unknown opcodes fall through as a no-op
    dec_next           = '0;
    dec_next.rs1       = inst[19:15];
    dec_next.rd        = inst[11:7];
    dec_next.src_a     = SRC_ZERO;
    dec_next.wb_sel    = WB_SUM;
    case (opcode)
      OP_IMM: begin
        dec_next.imm       = imm_i;
        dec_next.src_a     = SRC_RS1;
        dec_next.reg_write = 1'b1;
      end
      LUI: begin
        dec_next.imm       = imm_u;
        dec_next.reg_write = 1'b1;
      end
      AUIPC: begin
        dec_next.imm       = imm_u;
        dec_next.src_a     = SRC_PC;
        dec_next.reg_write = 1'b1;
      end
      JAL: begin
        // target pc + imm, rd gets pc + 4
        dec_next.imm       = imm_j;
        dec_next.src_a     = SRC_PC;
        dec_next.wb_sel    = WB_LINK;
        dec_next.reg_write = 1'b1;
        dec_next.is_jump   = 1'b1;
      end
      JALR: begin
        dec_next.imm       = imm_i;
        dec_next.src_a     = SRC_RS1;
        dec_next.wb_sel    = WB_LINK;
        dec_next.reg_write = 1'b1;
        dec_next.is_jump   = 1'b1;
      end
      SYSTEM: begin
        // treated as ebreak, no write
        dec_next.is_halt = 1'b1;
      end
      default: begin
        dec_next.reg_write = 1'b0;
        dec_next.is_jump   = 1'b0;
      end
    endcase
  end

  // free slot, or slot drains this cycle
  assign inst_ready = !dec_valid || exec_ready;
  assign accept     = inst_valid && inst_ready;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
    end else if (accept) begin
      dec_valid <= 1'b1;
    end else if (exec_ready) begin
      dec_valid <= 1'b0;
    end
  end

  // payload only, qualified by dec_valid
  always_ff @(posedge clk) begin
    if (accept) begin
      dec <= dec_next;
    end
  end

  // a stalled entry must not change under execute
  a_dec_hold: assert property (
    @(posedge clk) disable iff (!rst_n)
    dec_valid && !exec_ready |=> dec_valid && $stable(dec)
  );

endmodule

`default_nettype wire

// ==== hdl/core_pkg.sv ====
`default_nettype none

package core_pkg;

  // first adder operand
  // lui adds its immediate to zero
  typedef enum logic [1:0] {
    SRC_RS1  = 2'd0,
    SRC_PC   = 2'd1,
    SRC_ZERO = 2'd2
  } src_a_e;

  // value written back to rd
  typedef enum logic {
    // adder output
    WB_SUM  = 1'b0,
    // pc + 4 for jal and jalr
    WB_LINK = 1'b1
  } wb_sel_e;

  // decode register contents handed to execute
  typedef struct packed {
    rv_isa_pkg::reg_idx_t rs1;
    rv_isa_pkg::reg_idx_t rd;
    // final immediate, already extended and shifted
    rv_isa_pkg::word_t    imm;
    src_a_e               src_a;
    wb_sel_e              wb_sel;
    logic                 reg_write;
    logic                 is_jump;
    logic                 is_halt;
  } decoded_t;

  // one record per executed instruction
  typedef struct packed {
    logic                 valid;
    rv_isa_pkg::word_t    pc;
    rv_isa_pkg::reg_idx_t rd;
    logic                 reg_write;
    rv_isa_pkg::word_t    wdata;
    // address of the instruction expected next
    rv_isa_pkg::word_t    next_pc;
  } retire_t;

endpackage

`default_nettype wire

// ==== hdl/rv_isa_pkg.sv ====
`default_nettype none

`include "core_defs.svh"

package rv_isa_pkg;

  // one data word or byte address
  typedef logic [`XLEN-1:0] word_t;

  // raw instruction word, always 32 bits in RV32I
  typedef logic [31:0] inst_t;

  // register index as found in the rd and rs1 fields
  typedef logic [`REG_ADDR_W-1:0] reg_idx_t;

  // major opcodes in inst[6:0]
  // only the subset this core executes is listed
  typedef enum logic [6:0] {
    // addi and friends
    OP_IMM = 7'b001_0011,
    // load upper immediate
    LUI    = 7'b011_0111,
    // add upper immediate to pc
    AUIPC  = 7'b001_0111,
    // pc-relative jump and link
    JAL    = 7'b110_1111,
    // register-indirect jump and link
    JALR   = 7'b110_0111,
    // ebreak lives here
    SYSTEM = 7'b111_0011
  } opcode_e;

endpackage

`default_nettype wire

// ==== include/core_defs.svh ====
`ifndef CORE_DEFS_SVH
`define CORE_DEFS_SVH

// datapath and address width
`define XLEN 32

// architectural register count, x0 included
`define REG_COUNT 32

// bits needed to index the register file
`define REG_ADDR_W 5

// first instruction address after reset
`define RESET_PC 32'h8000_0000

// sequential pc increment, one 32-bit instruction
`define PC_STEP 32'd4

`endif
